//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP = tb_vga_display
FILELIST = vga_display.f
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_vga_display.sv
`timescale 1ns/1ns

module tb_vga_display;

    logic clk;
    logic rst;
    logic wr_valid;
    logic [6:0] wr_tile_x;
    logic [5:0] wr_tile_y;
    logic [2:0] wr_color;
    logic wr_ready, hsync, vsync, red, green, blue;

    // cases read from the file
    int case_op[$];
    int case_col[$];
    int case_row[$];
    int case_color[$];

    // shadow of what the screen shows plus writes not yet on screen
    int shadow_color[4800];
    bit shadow_known[4800];
    int pend_idx[$];
    int pend_color[$];

    // monitor state rebuilt from the pins
    int hpos, vline, frame_count;
    bit h_locked, v_locked;
    bit hs_prev, vs_prev, hs_fall_seen, vs_fall_seen;
    int hs_low, vs_low, hs_period, vs_period;
    int cycles, cycle_limit;

    vga_display u_dut (
        .clk(clk),
        .rst(rst),
        .wr_valid(wr_valid),
        .wr_tile_x(wr_tile_x),
        .wr_tile_y(wr_tile_y),
        .wr_color(wr_color),
        .wr_ready(wr_ready),
        .hsync(hsync),
        .vsync(vsync),
        .red(red),
        .green(green),
        .blue(blue)
    );

    always #20 clk = ~clk;

    task automatic check_val(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_pins_idle();
        check_val("hsync", 1, int'(hsync));
        check_val("vsync", 1, int'(vsync));
        check_val("rgb", 0, int'({red, green, blue}));
        check_val("wr_ready", 1, int'(wr_ready));
    endtask

    // anywhere outside the visible window seen at the pins
    function automatic int in_blanking();
        return int'(!(hpos >= 48 && hpos < 688 && vline >= 33 && vline < 513));
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // pin monitor samples where the pins are stable
    always @(negedge clk) begin
        if (!rst) begin
            hs_period++;
            vs_period++;
            if (!hsync && hs_prev) begin
                if (hs_fall_seen)
                    check_val("hsync period", 800, hs_period);
                hs_period = 0;
                hs_fall_seen = 1;
                hs_low = 0;
            end
            if (!vsync && vs_prev) begin
                if (vs_fall_seen)
                    check_val("vsync period", 420000, vs_period);
                vs_period = 0;
                vs_fall_seen = 1;
                vs_low = 0;
            end
            if (!hsync)
                hs_low++;
            if (!vsync)
                vs_low++;
            if (hsync && !hs_prev) begin
                check_val("hsync low width", 96, hs_low);
                hpos = 0; // first clock of back porch
                h_locked = 1;
            end else if (h_locked) begin
                hpos++;
            end
            if (vsync && !vs_prev) begin
                check_val("vsync low width", 1600, vs_low);
                vline = 0;
                v_locked = 1;
            end else if (v_locked && hpos == 48) begin
                vline++; // lines start at the first active pixel
            end
            if (h_locked && v_locked) begin
                if (hpos >= 48 && hpos < 688 && vline >= 33 && vline < 513) begin
                    int idx;
                    if (hpos == 48 && vline == 33) begin
                        frame_count++;
                        while (pend_idx.size() > 0) begin
                            idx = pend_idx.pop_front();
                            shadow_color[idx] = pend_color.pop_front();
                            shadow_known[idx] = 1;
                        end
                    end
                    idx = ((vline - 33) >> 3) * 80 + ((hpos - 48) >> 3);
                    if (shadow_known[idx])
                        check_val("tile rgb", shadow_color[idx], int'({red, green, blue}));
                end else begin
                    check_val("blank rgb", 0, int'({red, green, blue}));
                end
            end
            hs_prev = hsync;
            vs_prev = vsync;
        end
    end

    task automatic read_cases();
        int fd, n, col, row, color;
        string line, op;
        fd = $fopen("vga_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open vga_cases.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing cases file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%s %d %d %d", op, col, row, color);
                if (n == 4) begin
                    if (op == "write")
                        case_op.push_back(0);
                    else if (op == "burst")
                        case_op.push_back(1);
                    else if (op == "check")
                        case_op.push_back(2);
                    else begin
                        $display("unknown operation %s in cases file", op);
                        $display("TEST RESULT: FAIL");
                        $fatal(1, "bad cases file");
                    end
                    case_col.push_back(col);
                    case_row.push_back(row);
                    case_color.push_back(color);
                end
            end
        end
        $fclose(fd);
    endtask

    // one write held until the DUT takes it
    task automatic send_write(input int col, input int row, input int color);
        while (v_locked && vline >= 31 && vline <= 33)
            @(negedge clk); // keep clear of the frame start
        wr_valid = 1'b1;
        wr_tile_x = 7'(col);
        wr_tile_y = 6'(row);
        wr_color = 3'(color);
        while (!wr_ready)
            @(negedge clk);
        pend_idx.push_back(row * 80 + col); // transfers at the next rising edge
        pend_color.push_back(color);
        @(negedge clk);
        wr_valid = 1'b0;
    endtask

    task automatic send_burst(input int col, input int row, input int color);
        int accepted;
        bit saw_full;
        accepted = 0;
        saw_full = 0;
        while (!(vline >= 40 && vline <= 400))
            @(negedge clk);
        wr_valid = 1'b1;
        while (accepted < 6) begin
            wr_tile_x = 7'(col + accepted);
            wr_tile_y = 6'(row);
            wr_color = 3'(color);
            if (accepted < 4)
                check_val("wr_ready before full", 1, int'(wr_ready));
            if (accepted == 4 && !saw_full) begin
                check_val("wr_ready after fourth write", 0, int'(wr_ready));
                saw_full = 1;
            end
            if (wr_ready) begin
                if (accepted == 4)
                    check_val("wr_ready back only in blanking", 1, in_blanking());
                pend_idx.push_back(row * 80 + col + accepted);
                pend_color.push_back(color);
                accepted++;
            end
            @(negedge clk);
        end
        wr_valid = 1'b0;
    endtask

    initial begin
        int checks, target;
        clk = 1'b0;
        rst = 1'b1;
        wr_valid = 1'b0;
        wr_tile_x = '0;
        wr_tile_y = '0;
        wr_color = '0;
        hs_prev = 1'b1;
        vs_prev = 1'b1;
        void'($urandom(32'h7a7e0139));
        read_cases();
        checks = 0;
        foreach (case_op[i])
            if (case_op[i] == 2)
                checks++;
        cycle_limit = (2 * checks + 3) * 420000; // two frames per check case
        repeat (2) begin
            @(negedge clk);
            check_pins_idle();
        end
        rst = 1'b0;
        @(negedge clk);
        check_pins_idle();
        while (!v_locked)
            @(negedge clk);
        foreach (case_op[i]) begin
            if (case_op[i] == 0) begin
                send_write(case_col[i], case_row[i], case_color[i]);
                repeat (int'($urandom % 4)) @(negedge clk);
            end else if (case_op[i] == 1) begin
                send_burst(case_col[i], case_row[i], case_color[i]);
            end else begin
                target = frame_count + 2; // apply then check one full frame
                while (frame_count < target)
                    @(negedge clk);
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- tile_map.sv
`timescale 1ns/1ns

module tile_map (
    input  logic                          clk,
    input  logic                          we,
    input  logic [vga_pkg::tile_x_w-1:0]  wr_tile_x,
    input  logic [vga_pkg::tile_y_w-1:0]  wr_tile_y,
    input  logic [vga_pkg::color_w-1:0]   wr_color,
    input  logic [vga_pkg::coord_w-1:0]   rd_x,
    input  logic [vga_pkg::coord_w-1:0]   rd_y,
    output logic [vga_pkg::color_w-1:0]   rd_color
);

    import vga_pkg::*;

    localparam int depth = tile_cols * tile_rows;
    localparam int addr_w = $clog2(depth);

    logic [color_w-1:0] mem [depth];
    logic [addr_w-1:0] wr_addr, rd_addr;
    logic wr_in_range;

    // row-major: row * 80 + column
    function automatic logic [addr_w-1:0] tile_addr(
        input logic [tile_x_w-1:0] tx,
        input logic [tile_y_w-1:0] ty
    );
        return addr_w'(ty) * addr_w'(tile_cols) + addr_w'(tx);
    endfunction

    assign wr_addr = tile_addr(wr_tile_x, wr_tile_y);
    assign rd_addr = tile_addr(rd_x[tile_shift +: tile_x_w], rd_y[tile_shift +: tile_y_w]);

    // writes outside the 80 x 60 map are dropped
    assign wr_in_range = (wr_tile_x < tile_x_w'(tile_cols)) && (wr_tile_y < tile_y_w'(tile_rows));

    always_ff @(posedge clk) begin
        if (we && wr_in_range)
            mem[wr_addr] <= wr_color;
        rd_color <= mem[rd_addr]; // one clock read latency
    end

endmodule

//--- tile_write_queue.sv
`timescale 1ns/1ns

module tile_write_queue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_valid,
    input  logic [vga_pkg::tile_x_w-1:0]  wr_tile_x,
    input  logic [vga_pkg::tile_y_w-1:0]  wr_tile_y,
    input  logic [vga_pkg::color_w-1:0]   wr_color,
    input  logic                          vblank,
    output logic                          wr_ready,
    output logic                          map_we,
    output logic [vga_pkg::tile_x_w-1:0]  map_tile_x,
    output logic [vga_pkg::tile_y_w-1:0]  map_tile_y,
    output logic [vga_pkg::color_w-1:0]   map_color
);

    import vga_pkg::*;

    localparam int depth = 4;
    localparam int ptr_w = $clog2(depth);
    localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(depth);

    logic [tile_x_w-1:0] q_x [depth];
    logic [tile_y_w-1:0] q_y [depth];
    logic [color_w-1:0] q_color [depth];

    logic [ptr_w-1:0] wr_ptr, rd_ptr;
    logic [ptr_w:0] count;
    logic push, pop;

    assign wr_ready = (count != full_count);
    assign push = wr_valid && wr_ready;
    assign pop = vblank && (count != '0); // drain only while blanked

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_x[wr_ptr] <= wr_tile_x;
            q_y[wr_ptr] <= wr_tile_y;
            q_color[wr_ptr] <= wr_color;
        end
    end

    // oldest entry goes to the tile map
    assign map_we = pop;
    assign map_tile_x = q_x[rd_ptr];
    assign map_tile_y = q_y[rd_ptr];
    assign map_color = q_color[rd_ptr];

endmodule

//--- vga_cases.txt
# operation column row color
# write = one tile, burst = six tiles from column on, check = wait two frames
write 0 0 7
write 79 0 4
write 0 59 2
write 79 59 1
write 40 30 5
write 10 5 3
check 0 0 0
burst 20 12 6
check 0 0 0
write 40 30 2
write 0 0 1
write 41 30 7
write 20 12 3
check 0 0 0
write 25 12 4
write 79 59 6
write 5 50 7
check 0 0 0

//--- vga_display.f
vga_pkg.sv
vga_timing.sv
tile_write_queue.sv
tile_map.sv
vga_pixel_out.sv
vga_display.sv
tb_vga_display.sv

//--- vga_display.sv
`timescale 1ns/1ns

module vga_display #(
    parameter logic [vga_pkg::coord_w-1:0] h_active_last = vga_pkg::h_active_last,
    parameter logic [vga_pkg::coord_w-1:0] h_front_last = vga_pkg::h_front_last,
    parameter logic [vga_pkg::coord_w-1:0] h_pulse_last = vga_pkg::h_pulse_last,
    parameter logic [vga_pkg::coord_w-1:0] h_back_last = vga_pkg::h_back_last,
    parameter logic [vga_pkg::coord_w-1:0] v_active_last = vga_pkg::v_active_last,
    parameter logic [vga_pkg::coord_w-1:0] v_front_last = vga_pkg::v_front_last,
    parameter logic [vga_pkg::coord_w-1:0] v_pulse_last = vga_pkg::v_pulse_last,
    parameter logic [vga_pkg::coord_w-1:0] v_back_last = vga_pkg::v_back_last
) (
    input  logic                          clk,  // 25 MHz pixel clock
    input  logic                          rst,
    input  logic                          wr_valid,
    input  logic [vga_pkg::tile_x_w-1:0]  wr_tile_x,
    input  logic [vga_pkg::tile_y_w-1:0]  wr_tile_y,
    input  logic [vga_pkg::color_w-1:0]   wr_color,
    output logic                          wr_ready,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          red,
    output logic                          green,
    output logic                          blue
);

    import vga_pkg::*;

    logic [coord_w-1:0] h_count, v_count;
    logic h_active, v_active, vblank;
    logic hsync_raw, vsync_raw;

    logic map_we;
    logic [tile_x_w-1:0] map_tile_x;
    logic [tile_y_w-1:0] map_tile_y;
    logic [color_w-1:0] map_color;
    logic [color_w-1:0] rd_color;

    vga_timing #(
        .h_active_last(h_active_last),
        .h_front_last(h_front_last),
        .h_pulse_last(h_pulse_last),
        .h_back_last(h_back_last),
        .v_active_last(v_active_last),
        .v_front_last(v_front_last),
        .v_pulse_last(v_pulse_last),
        .v_back_last(v_back_last)
    ) u_timing (
        .clk(clk),
        .rst(rst),
        .h_count(h_count),
        .v_count(v_count),
        .h_active(h_active),
        .v_active(v_active),
        .vblank(vblank),
        .hsync_raw(hsync_raw),
        .vsync_raw(vsync_raw)
    );

    tile_write_queue u_queue (
        .clk(clk),
        .rst(rst),
        .wr_valid(wr_valid),
        .wr_tile_x(wr_tile_x),
        .wr_tile_y(wr_tile_y),
        .wr_color(wr_color),
        .vblank(vblank),
        .wr_ready(wr_ready),
        .map_we(map_we),
        .map_tile_x(map_tile_x),
        .map_tile_y(map_tile_y),
        .map_color(map_color)
    );

    tile_map u_map (
        .clk(clk),
        .we(map_we),
        .wr_tile_x(map_tile_x),
        .wr_tile_y(map_tile_y),
        .wr_color(map_color),
        .rd_x(h_count),
        .rd_y(v_count),
        .rd_color(rd_color)
    );

    vga_pixel_out u_out (
        .clk(clk),
        .rst(rst),
        .h_active(h_active),
        .v_active(v_active),
        .hsync_raw(hsync_raw),
        .vsync_raw(vsync_raw),
        .rd_color(rd_color),
        .hsync(hsync),
        .vsync(vsync),
        .red(red),
        .green(green),
        .blue(blue)
    );

endmodule

//--- vga_pixel_out.sv
`timescale 1ns/1ns

module vga_pixel_out (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         h_active,
    input  logic                         v_active,
    input  logic                         hsync_raw,
    input  logic                         vsync_raw,
    input  logic [vga_pkg::color_w-1:0]  rd_color,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         red,
    output logic                         green,
    output logic                         blue
);

    import vga_pkg::*;

    logic hsync_d, vsync_d;
    logic active_d;
    logic [color_w-1:0] pix;

    // stage one lines up with the tile map read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
            active_d <= 1'b0;
        end else begin
            hsync_d <= hsync_raw;
            vsync_d <= vsync_raw;
            active_d <= h_active && v_active;
        end
    end

    // black outside the visible window
    assign pix = active_d ? rd_color : '0;

    // stage two drives the pins
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            red <= 1'b0;
            green <= 1'b0;
            blue <= 1'b0;
        end else begin
            hsync <= hsync_d;
            vsync <= vsync_d;
            red <= pix[2];   // r g b order
            green <= pix[1];
            blue <= pix[0];
        end
    end

endmodule

//--- vga_pkg.sv
package vga_pkg;

    // pixel color, one bit each of red, green, blue
    localparam int color_w = 3;

    // tile map geometry
    localparam int tile_cols = 80;
    localparam int tile_rows = 60;
    localparam int tile_x_w = 7;    // holds 0..79
    localparam int tile_y_w = 6;    // holds 0..59
    localparam int tile_shift = 3;  // 8 x 8 pixels per tile

    localparam int coord_w = 10;    // pixel and line counters

    // last count of each phase, inclusive, so phase length is limit + 1
    // 640 + 16 + 96 + 48 = 800 clocks per line
    localparam logic [coord_w-1:0] h_active_last = 10'd639;
    localparam logic [coord_w-1:0] h_front_last = 10'd15;
    localparam logic [coord_w-1:0] h_pulse_last = 10'd95;
    localparam logic [coord_w-1:0] h_back_last = 10'd47;

    // 480 + 10 + 2 + 33 = 525 lines per frame
    localparam logic [coord_w-1:0] v_active_last = 10'd479;
    localparam logic [coord_w-1:0] v_front_last = 10'd9;
    localparam logic [coord_w-1:0] v_pulse_last = 10'd1;
    localparam logic [coord_w-1:0] v_back_last = 10'd32;

    // phase of either timing machine
    typedef enum logic [1:0] {
        ph_active = 2'b00,
        ph_front = 2'b01,
        ph_pulse = 2'b10,
        ph_back = 2'b11
    } phase_t;

endpackage

//--- vga_timing.sv
`timescale 1ns/1ns

module vga_timing #(
    parameter logic [vga_pkg::coord_w-1:0] h_active_last = vga_pkg::h_active_last,
    parameter logic [vga_pkg::coord_w-1:0] h_front_last = vga_pkg::h_front_last,
    parameter logic [vga_pkg::coord_w-1:0] h_pulse_last = vga_pkg::h_pulse_last,
    parameter logic [vga_pkg::coord_w-1:0] h_back_last = vga_pkg::h_back_last,
    parameter logic [vga_pkg::coord_w-1:0] v_active_last = vga_pkg::v_active_last,
    parameter logic [vga_pkg::coord_w-1:0] v_front_last = vga_pkg::v_front_last,
    parameter logic [vga_pkg::coord_w-1:0] v_pulse_last = vga_pkg::v_pulse_last,
    parameter logic [vga_pkg::coord_w-1:0] v_back_last = vga_pkg::v_back_last
) (
    input  logic                         clk,
    input  logic                         rst,
    output logic [vga_pkg::coord_w-1:0]  h_count,
    output logic [vga_pkg::coord_w-1:0]  v_count,
    output logic                         h_active,
    output logic                         v_active,
    output logic                         vblank,
    output logic                         hsync_raw,
    output logic                         vsync_raw
);

    import vga_pkg::*;

    phase_t h_phase, h_follow;
    phase_t v_phase, v_follow;

    logic [coord_w-1:0] h_cnt, h_limit;
    logic [coord_w-1:0] v_cnt, v_limit;
    logic h_wrap, v_wrap;
    logic line_end;

    // horizontal limit and following phase
    always_comb begin
        h_limit = h_active_last;
        h_follow = ph_front;
        case (h_phase)
            ph_active: begin
                h_limit = h_active_last;
                h_follow = ph_front;
            end
            ph_front: begin
                h_limit = h_front_last;
                h_follow = ph_pulse;
            end
            ph_pulse: begin
                h_limit = h_pulse_last;
                h_follow = ph_back;
            end
            ph_back: begin
                h_limit = h_back_last;
                h_follow = ph_active;
            end
        endcase
    end

    assign h_wrap = (h_cnt == h_limit);
    assign line_end = h_wrap && (h_phase == ph_back); // last clock of the line

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            h_phase <= ph_active;
        end else if (h_wrap) begin
            h_cnt <= '0;
            h_phase <= h_follow;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // vertical machine, same shape but counts lines
    always_comb begin
        v_limit = v_active_last;
        v_follow = ph_front;
        case (v_phase)
            ph_active: begin
                v_limit = v_active_last;
                v_follow = ph_front;
            end
            ph_front: begin
                v_limit = v_front_last;
                v_follow = ph_pulse;
            end
            ph_pulse: begin
                v_limit = v_pulse_last;
                v_follow = ph_back;
            end
            ph_back: begin
                v_limit = v_back_last;
                v_follow = ph_active;
            end
        endcase
    end

    assign v_wrap = (v_cnt == v_limit);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v_cnt <= '0;
            v_phase <= ph_active;
        end else if (line_end) begin // step only once per line
            if (v_wrap) begin
                v_cnt <= '0;
                v_phase <= v_follow;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    assign h_active = (h_phase == ph_active);
    assign v_active = (v_phase == ph_active);
    assign vblank = ~v_active;

    // sync pulses are active low
    assign hsync_raw = (h_phase != ph_pulse);
    assign vsync_raw = (v_phase != ph_pulse);

    // position reads as zero outside the visible area
    assign h_count = h_active ? h_cnt : '0;
    assign v_count = v_active ? v_cnt : '0;

endmodule
